//--- rtl/dmc_clk_settings.svh
`ifndef DMC_CLK_SETTINGS_SVH
`define DMC_CLK_SETTINGS_SVH

// number of DQS groups, each with its own strobe delay line
`define DMC_DQ_GROUPS_D 2

// width of a delay tap count, so a line can delay by 0 to 2**W - 1 extra cycles
`define DMC_TAP_W_D 4

// width of the divide count that sets the 1x clock half period
`define DMC_DS_W_D 4

// credits the sender owns after reset, equal to the config FIFO depth
`define DMC_CFG_CREDITS_D 2

// number of 2x cycles that rst_o stays high in each hold
`define DMC_RST_HOLD_D 8

`endif

//--- rtl/dmc_clk_pkg.sv
`include "dmc_clk_settings.svh"

package dmc_clk_pkg;

  // committed or staged delay of one DQS group, in 2x cycles
  typedef logic [`DMC_TAP_W_D-1:0] dly_taps_t;

  // downsampler reload value, the 1x clock toggles every value plus one cycles
  typedef logic [`DMC_DS_W_D-1:0] ds_val_t;

  // one config word payload
  typedef logic [7:0] cfg_data_t;

  // config word address, selects how the payload is interpreted
  typedef enum logic [1:0] {
    CFG_DS_VAL  = 2'd0,
    CFG_DLY     = 2'd1,
    CFG_CTRL    = 2'd2,
    CFG_TRIGGER = 2'd3
  } cfg_addr_e;

  // controller reset sequencer states
  typedef enum logic [1:0] {
    SEQ_RESET = 2'd0,
    SEQ_HOLD  = 2'd1,
    SEQ_RUN   = 2'd2,
    SEQ_PARK  = 2'd3
  } seq_state_e;

endpackage

//--- rtl/dmc_cfg_if.sv
`include "dmc_clk_settings.svh"

interface dmc_cfg_if
  import dmc_clk_pkg::*;
();

  // committed settings, all driven by the config client
  ds_val_t                             ds_val;
  logic                                ds_hold;
  logic                                ds_change;
  dly_taps_t [`DMC_DQ_GROUPS_D-1:0]    taps;

  // the sequencer is absorbing a change and cannot take another one yet
  logic                                seq_busy;

  modport client (
    output ds_val, ds_hold, ds_change, taps,
    input  seq_busy
  );

  modport seq (
    input  ds_change, ds_hold,
    output seq_busy
  );

  modport ds (input ds_val);

  modport dly (input taps);

endinterface

//--- rtl/dmc_tag_client.sv
`include "dmc_clk_settings.svh"

module dmc_tag_client
  import dmc_clk_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      cfg_v_i,
  input  cfg_addr_e cfg_addr_i,
  input  cfg_data_t cfg_data_i,
  output logic      cfg_credit_o,
  dmc_cfg_if.client cfg
);

  localparam int FIFO_DEPTH = `DMC_CFG_CREDITS_D;
  localparam int PTR_W      = $clog2(FIFO_DEPTH);
  localparam int CNT_W      = $clog2(FIFO_DEPTH + 1);

  cfg_addr_e addr_mem [FIFO_DEPTH];
  cfg_data_t data_mem [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  cfg_addr_e head_addr;
  cfg_data_t head_data;
  logic      seq_word;
  logic      push;
  logic      pop;

  dly_taps_t [`DMC_DQ_GROUPS_D-1:0] staged_q;
  dly_taps_t [`DMC_DQ_GROUPS_D-1:0] taps_q;
  ds_val_t                          ds_val_q;
  logic                             hold_q;
  logic                             change_q;
  logic                             credit_q;

  assign head_addr = addr_mem[rd_ptr_q];
  assign head_data = data_mem[rd_ptr_q];
  assign seq_word  = (head_addr == CFG_DS_VAL) || (head_addr == CFG_CTRL);

  // a word the sequencer must absorb waits at the head until the sequencer is idle;
  // change_q covers the cycle before seq_busy can rise
  assign push = cfg_v_i;
  assign pop  = (count_q != '0) && !(seq_word && (cfg.seq_busy || change_q));

  always_ff @(posedge clk_i) begin
    if (push) begin
      addr_mem[wr_ptr_q] <= cfg_addr_i;
      data_mem[wr_ptr_q] <= cfg_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      wr_ptr_q <= wr_ptr_q + PTR_W'(push);
      rd_ptr_q <= rd_ptr_q + PTR_W'(pop);
      count_q  <= count_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  // the popped word updates the settings, and the credit goes back in the same cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      staged_q <= '0;
      taps_q   <= '0;
      ds_val_q <= '0;
      hold_q   <= 1'b0;
      change_q <= 1'b0;
      credit_q <= 1'b0;
    end else begin
      credit_q <= pop;
      change_q <= pop && seq_word;
      if (pop) begin
        unique case (head_addr)
          CFG_DS_VAL:  ds_val_q <= head_data[`DMC_DS_W_D-1:0];
          CFG_DLY:     staged_q[head_data[`DMC_TAP_W_D]] <= head_data[`DMC_TAP_W_D-1:0];
          CFG_CTRL:    hold_q <= head_data[0];
          CFG_TRIGGER: taps_q <= staged_q;
        endcase
      end
    end
  end

  assign cfg_credit_o  = credit_q;
  assign cfg.ds_val    = ds_val_q;
  assign cfg.ds_hold   = hold_q;
  assign cfg.ds_change = change_q;
  assign cfg.taps      = taps_q;

endmodule

//--- rtl/dmc_clk_seq.sv
`include "dmc_clk_settings.svh"

module dmc_clk_seq
  import dmc_clk_pkg::*;
(
  input  logic   clk_i,
  input  logic   reset_i,
  dmc_cfg_if.seq cfg,
  output logic   ds_reset_o,
  output logic   rst_o,
  output logic   ready_o
);

  localparam int TIMER_W = $clog2(`DMC_RST_HOLD_D + 1);
  localparam logic [TIMER_W-1:0] HOLD_LOAD = TIMER_W'(`DMC_RST_HOLD_D - 1);

  seq_state_e        state_q;
  seq_state_e        state_n;
  logic [TIMER_W-1:0] timer_q;
  logic               load_timer;

  // a divide count or power change always wins over the normal progression
  always_comb begin
    state_n = state_q;
    if (cfg.ds_change) begin
      state_n = cfg.ds_hold ? SEQ_PARK : SEQ_HOLD;
    end else begin
      unique case (state_q)
        SEQ_RESET: state_n = SEQ_HOLD;
        SEQ_HOLD: begin
          if (timer_q == '0) begin
            state_n = SEQ_RUN;
          end
        end
        SEQ_RUN:  state_n = SEQ_RUN;
        SEQ_PARK: state_n = SEQ_PARK;
      endcase
    end
  end

  // the timer restarts on every entry into the hold, including a repeated change
  assign load_timer = (state_n == SEQ_HOLD) && ((state_q != SEQ_HOLD) || cfg.ds_change);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= SEQ_RESET;
      timer_q <= HOLD_LOAD;
    end else begin
      state_q <= state_n;
      if (load_timer) begin
        timer_q <= HOLD_LOAD;
      end else if (timer_q != '0) begin
        timer_q <= timer_q - 1'b1;
      end
    end
  end

  // the controller sees reset everywhere except in the run state
  assign rst_o   = (state_q != SEQ_RUN);
  assign ready_o = (state_q == SEQ_RUN);

  assign cfg.seq_busy = (state_q == SEQ_HOLD);

  // keep the divider cleared while parked so the 1x clock stops and restarts cleanly
  assign ds_reset_o = (state_q == SEQ_RESET) || (state_q == SEQ_PARK);

endmodule

//--- rtl/dmc_clk_downsample.sv
module dmc_clk_downsample
  import dmc_clk_pkg::*;
(
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  hold_i,
  dmc_cfg_if.ds cfg,
  output logic  clk_1x_o
);

  ds_val_t count_q;
  logic    clk_q;

  // down counter, at zero it reloads and flips the 1x clock;
  // with a divide count of 0 the output toggles every 2x cycle
  always_ff @(posedge clk_i) begin
    if (reset_i || hold_i) begin
      count_q <= '0;
      clk_q   <= 1'b0;
    end else if (count_q == '0) begin
      count_q <= cfg.ds_val;
      clk_q   <= ~clk_q;
    end else begin
      count_q <= count_q - 1'b1;
    end
  end

  // the 1x clock is a register on the 2x clock, not a generated clock
  assign clk_1x_o = clk_q;

endmodule

//--- rtl/dmc_dly_line.sv
`include "dmc_clk_settings.svh"

module dmc_dly_line (
  input  logic                         clk_i,
  input  logic                         reset_i,
  dmc_cfg_if.dly                       cfg,
  input  logic [`DMC_DQ_GROUPS_D-1:0]  dqs_i,
  output logic [`DMC_DQ_GROUPS_D-1:0]  dqs_o
);

  localparam int DEPTH = 1 << `DMC_TAP_W_D;

  for (genvar g = 0; g < `DMC_DQ_GROUPS_D; g++) begin : g_group
    // the live input forms tap 0 of the window, so the register holds one stage less
    logic [DEPTH-2:0] shift_q;
    logic [DEPTH-1:0] window;
    logic             dqs_q;

    assign window = {shift_q, dqs_i[g]};

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        shift_q <= '0;
        dqs_q   <= 1'b0;
      end else begin
        shift_q <= window[DEPTH-2:0];
        // tap n sees the input n cycles late, and the output register adds one more
        dqs_q   <= window[cfg.taps[g]];
      end
    end

    assign dqs_o[g] = dqs_q;
  end

endmodule

//--- rtl/dmc_clk_rst_gen.sv
`include "dmc_clk_settings.svh"

module dmc_clk_rst_gen
  import dmc_clk_pkg::*;
(
  input  logic                         ext_clk_i,
  input  logic                         reset_i,
  input  logic                         cfg_v_i,
  input  cfg_addr_e                    cfg_addr_i,
  input  cfg_data_t                    cfg_data_i,
  output logic                         cfg_credit_o,
  input  logic [`DMC_DQ_GROUPS_D-1:0]  dqs_i,
  output logic [`DMC_DQ_GROUPS_D-1:0]  dqs_o,
  output logic                         clk_1x_o,
  output logic                         rst_o,
  output logic                         ready_o
);

  logic ds_reset;

  dmc_cfg_if cfg ();

  // config words arrive here and become committed settings
  dmc_tag_client u_client (
    .clk_i        (ext_clk_i),
    .reset_i      (reset_i),
    .cfg_v_i      (cfg_v_i),
    .cfg_addr_i   (cfg_addr_i),
    .cfg_data_i   (cfg_data_i),
    .cfg_credit_o (cfg_credit_o),
    .cfg          (cfg)
  );

  dmc_clk_seq u_seq (
    .clk_i      (ext_clk_i),
    .reset_i    (reset_i),
    .cfg        (cfg),
    .ds_reset_o (ds_reset),
    .rst_o      (rst_o),
    .ready_o    (ready_o)
  );

  // the sequencer can hold the divider in reset to save power
  dmc_clk_downsample u_ds (
    .clk_i    (ext_clk_i),
    .reset_i  (reset_i),
    .hold_i   (ds_reset),
    .cfg      (cfg),
    .clk_1x_o (clk_1x_o)
  );

  dmc_dly_line u_dly (
    .clk_i   (ext_clk_i),
    .reset_i (reset_i),
    .cfg     (cfg),
    .dqs_i   (dqs_i),
    .dqs_o   (dqs_o)
  );

endmodule

//--- tests/dmc_clk_rst_gen_chk.sv
`include "dmc_clk_settings.svh"

module dmc_clk_rst_gen_chk (
  input logic clk_i,
  input logic reset_i,
  input logic cfg_v_i,
  input logic cfg_credit_o,
  input logic rst_o,
  input logic ready_o,
  input logic clk_1x_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // words the sender has written whose credit has not come back yet
  int outstanding_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      outstanding_q <= 0;
    end else begin
      outstanding_q <= outstanding_q + (cfg_v_i ? 1 : 0) - (cfg_credit_o ? 1 : 0);
    end
  end

  credit_range_a: assert property (@(posedge clk_i) disable iff (reset_i)
      (outstanding_q >= 0) && (outstanding_q <= `DMC_CFG_CREDITS_D))
    else $error("outstanding config credits out of range: %0d", outstanding_q);

  ready_rst_a: assert property (@(posedge clk_i) disable iff (reset_i) ready_o |-> !rst_o)
    else $error("ready_o is high while rst_o is high");

  // the first cycle after a reset edge must show the idle reset state
  reset_state_a: assert property (@(posedge clk_i) reset_i |=> (rst_o && !clk_1x_o))
    else $error("rst_o low or clk_1x_o high right after reset");

endmodule

bind dmc_clk_rst_gen dmc_clk_rst_gen_chk u_chk (
  .clk_i        (ext_clk_i),
  .reset_i      (reset_i),
  .cfg_v_i      (cfg_v_i),
  .cfg_credit_o (cfg_credit_o),
  .rst_o        (rst_o),
  .ready_o      (ready_o),
  .clk_1x_o     (clk_1x_o)
);

//--- tests/dmc_clk_rst_gen_tb.sv
`include "dmc_clk_settings.svh"

module dmc_clk_rst_gen_tb
  import dmc_clk_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int GROUPS    = `DMC_DQ_GROUPS_D;
  localparam int CREDITS   = `DMC_CFG_CREDITS_D;
  localparam int NUM_TESTS = 8;

  typedef enum logic [2:0] {OP_RESET, OP_CREDIT, OP_DELAY, OP_DIVIDE, OP_HOLD} op_e;

  typedef struct packed {
    op_e       op;
    cfg_addr_e addr;
    cfg_data_t data;
    int        expected;
    int        budget;
  } test_t;

  logic              clk;
  logic              reset_i;
  logic              cfg_v_i;
  cfg_addr_e         cfg_addr_i;
  cfg_data_t         cfg_data_i;
  logic              cfg_credit_o;
  logic [GROUPS-1:0] dqs_i;
  logic [GROUPS-1:0] dqs_o;
  logic              clk_1x_o;
  logic              rst_o;
  logic              ready_o;

  test_t             tests [NUM_TESTS];
  logic [GROUPS-1:0] hist [$];
  dly_taps_t         model_taps [GROUPS];
  logic [31:0]       lfsr_q;
  bit                check_dqs;
  int                credits;
  int                credit_pulses;
  int                div_spacing;
  int                errors;
  int                test_errors;
  int                passed;
  int                cycles;
  int                cycle_limit;

  dmc_clk_rst_gen DUT (
    .ext_clk_i    (clk),
    .reset_i      (reset_i),
    .cfg_v_i      (cfg_v_i),
    .cfg_addr_i   (cfg_addr_i),
    .cfg_data_i   (cfg_data_i),
    .cfg_credit_o (cfg_credit_o),
    .dqs_i        (dqs_i),
    .dqs_o        (dqs_o),
    .clk_1x_o     (clk_1x_o),
    .rst_o        (rst_o),
    .ready_o      (ready_o)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("run stopped after %0d cycles before the tests finished", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic check_true(input bit ok, input string msg);
    assert (ok) else begin
      errors++;
      test_errors++;
      $display("FAILED at %0t: %s", $time, msg);
    end
  endtask

  task automatic fail_plain(input string msg);
    errors++;
    test_errors++;
    $display("%s", msg);
  endtask

  // one clock, then sample outputs and drive new strobe bits 2 ns after the edge
  task automatic step();
    logic [GROUPS-1:0] bits;
    @(posedge clk);
    #2;
    if (cfg_credit_o) begin
      credits++;
      credit_pulses++;
    end
    check_true(credits <= CREDITS, "sender holds more credits than the FIFO depth");
    if (check_dqs) begin
      for (int g = 0; g < GROUPS; g++) begin
        check_true(dqs_o[g] === hist[model_taps[g]][g],
                   $sformatf("dqs_o[%0d] is %b with %0d taps", g, dqs_o[g], model_taps[g]));
      end
    end
    for (int g = 0; g < GROUPS; g++) begin
      lfsr_q = lfsr_next(lfsr_q);
      bits[g] = lfsr_q[0];
    end
    dqs_i = bits;
    hist.push_front(bits);
    void'(hist.pop_back());
  endtask

  task automatic send_word(input cfg_addr_e addr, input cfg_data_t data);
    int waited;
    waited = 0;
    while (credits == 0 && waited < 50) begin
      step();
      waited++;
    end
    if (credits == 0) begin
      fail_plain("no credit came back, so a config word could not be sent");
    end else begin
      cfg_v_i = 1'b1;
      cfg_addr_i = addr;
      cfg_data_i = data;
      credits--;
      step();
      cfg_v_i = 1'b0;
    end
  endtask

  // wait until every word has left the FIFO and its credit is back
  task automatic drain();
    int waited;
    waited = 0;
    while (credits < CREDITS && waited < 40) begin
      step();
      waited++;
    end
    if (credits < CREDITS) fail_plain("config credits did not all come back");
  endtask

  task automatic wait_ready(input logic level, input int limit, output int waited);
    waited = 0;
    while (ready_o !== level && waited < limit) begin
      step();
      waited++;
    end
    if (ready_o !== level) begin
      fail_plain($sformatf("ready_o did not go to %0b within %0d cycles", level, limit));
    end
  endtask

  // the gap before the first toggle seen is not measured because its phase is free
  task automatic check_toggles(input int spacing);
    logic prev;
    int   gap;
    int   seen;
    int   waited;
    prev = clk_1x_o;
    gap = 0;
    seen = 0;
    waited = 0;
    while (seen < 5 && waited < 100) begin
      step();
      waited++;
      gap++;
      if (clk_1x_o !== prev) begin
        if (seen > 0) begin
          check_true(gap == spacing,
                     $sformatf("clk_1x_o toggled after %0d cycles, expected %0d", gap, spacing));
        end
        seen++;
        gap = 0;
        prev = clk_1x_o;
      end
    end
    if (seen < 5) fail_plain("clk_1x_o stopped toggling");
  endtask

  task automatic run_test(input test_t t);
    int waited;
    int start;
    case (t.op)
      OP_RESET: begin
        reset_i = 1'b1;
        step();
        step();
        reset_i = 1'b0;
        credits = CREDITS;
        waited = 0;
        while (ready_o !== 1'b1 && waited < 40) begin
          check_true(rst_o === 1'b1, "rst_o dropped before ready_o rose");
          check_true(cfg_credit_o === 1'b0, "credit pulse before any word was sent");
          step();
          waited++;
        end
        // the first cycle out of reset leaves the reset state and the hold follows
        check_true(waited == t.expected + 1,
                   $sformatf("ready_o rose %0d cycles after reset", waited));
      end
      OP_CREDIT: begin
        start = credit_pulses;
        send_word(t.addr, t.data);
        send_word(t.addr, t.data);
        drain();
        check_true(credit_pulses - start == t.expected,
                   $sformatf("%0d credit pulses for two words", credit_pulses - start));
      end
      OP_DELAY: begin
        // staged taps must leave the output on the committed taps until the trigger
        check_dqs = 1'b1;
        send_word(t.addr, t.data);
        drain();
        repeat (10) step();
        send_word(CFG_TRIGGER, 8'h00);
        drain();
        // the trigger was applied at the last edge, so the next output uses the new taps
        model_taps[t.data[`DMC_TAP_W_D]] = dly_taps_t'(t.expected);
        repeat (40) step();
        check_dqs = 1'b0;
      end
      OP_DIVIDE: begin
        send_word(t.addr, t.data);
        drain();
        wait_ready(1'b0, 5, waited);
        wait_ready(1'b1, 20, waited);
        div_spacing = t.expected;
        check_toggles(t.expected);
      end
      OP_HOLD: begin
        send_word(t.addr, t.data);
        drain();
        wait_ready(1'b0, 5, waited);
        step();
        repeat (12) begin
          check_true(clk_1x_o === 1'b0, "clk_1x_o moved while the divider is held");
          check_true(ready_o === 1'b0, "ready_o high while the divider is held");
          step();
        end
        send_word(t.addr, 8'h00);
        drain();
        wait_ready(1'b1, 20, waited);
        // the change pulse takes one cycle to reach the sequencer before the hold
        check_true(waited == t.expected + 1,
                   $sformatf("ready_o came back %0d cycles after the hold cleared", waited));
        check_toggles(div_spacing);
      end
      default: fail_plain("unknown operation in the test table");
    endcase
  endtask

  initial begin
    op_e op;
    clk = 1'b0;
    reset_i = 1'b1;
    cfg_v_i = 1'b0;
    cfg_addr_i = CFG_DS_VAL;
    cfg_data_i = '0;
    dqs_i = '0;
    lfsr_q = 32'h6ea119e7;
    check_dqs = 1'b0;
    credits = CREDITS;
    credit_pulses = 0;
    div_spacing = 1;
    errors = 0;
    passed = 0;
    cycles = 0;
    for (int g = 0; g < GROUPS; g++) model_taps[g] = '0;
    repeat (24) hist.push_back('0);

    // operation, address, data, expected value, cycle budget
    tests[0] = '{OP_RESET, CFG_DS_VAL, 8'h00, `DMC_RST_HOLD_D, 50};
    tests[1] = '{OP_CREDIT, CFG_DLY, 8'h00, 2, 40};
    tests[2] = '{OP_DELAY, CFG_DLY, 8'h05, 5, 90};
    tests[3] = '{OP_DELAY, CFG_DLY, 8'h1b, 11, 90};
    tests[4] = '{OP_DELAY, CFG_DLY, 8'h0f, 15, 90};
    tests[5] = '{OP_DIVIDE, CFG_DS_VAL, 8'h01, 2, 60};
    tests[6] = '{OP_DIVIDE, CFG_DS_VAL, 8'h03, 4, 60};
    tests[7] = '{OP_HOLD, CFG_CTRL, 8'h01, `DMC_RST_HOLD_D, 100};
    cycle_limit = 100;
    for (int i = 0; i < NUM_TESTS; i++) cycle_limit += tests[i].budget;

    for (int i = 0; i < NUM_TESTS; i++) begin
      test_errors = 0;
      op = tests[i].op;
      run_test(tests[i]);
      $display("test %0d %s: %s", i, op.name(), (test_errors == 0) ? "passed" : "failed");
      if (test_errors == 0) passed++;
    end

    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             NUM_TESTS, passed, NUM_TESTS - passed, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+rtl
rtl/dmc_clk_pkg.sv
rtl/dmc_cfg_if.sv
rtl/dmc_tag_client.sv
rtl/dmc_clk_seq.sv
rtl/dmc_clk_downsample.sv
rtl/dmc_dly_line.sv
rtl/dmc_clk_rst_gen.sv
tests/dmc_clk_rst_gen_chk.sv
tests/dmc_clk_rst_gen_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= dmc_clk_rst_gen_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation log $(LOG) reports success"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
